/* tcp_tx_pkg.sv */
package tcp_tx_pkg;

  typedef logic [31:0] tcp_num_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] port_t;
  typedef logic [7:0]  tcp_flags_t;

  // TCP flag bits
  localparam tcp_flags_t tcp_flag_ack = 8'h10;
  localparam tcp_flags_t tcp_flag_psh = 8'h08;

  // Fixed IPv4 header fields for every segment of this connection
  localparam logic [7:0]  ipv4_ver_ihl   = 8'h45;
  localparam logic [7:0]  ipv4_ttl       = 8'd64;
  localparam logic [7:0]  ipv4_proto_tcp = 8'd6;
  localparam logic [15:0] ipv4_flags_df  = 16'h4000;

  // Twenty bytes of TCP header, no options
  localparam logic [3:0] tcp_data_offset = 4'd5;

  // IPv4 plus TCP header, in bytes and in 32-bit words
  localparam logic [15:0] hdr_len   = 16'd40;
  localparam int          hdr_words = 10;

  // Words the downstream can absorb before it returns credit
  localparam int credit_depth = 4;
  localparam int credit_w     = 3;

  // Register map of the configuration write port
  localparam logic [3:0] reg_loc_ip = 4'd0;
  localparam logic [3:0] reg_rem_ip = 4'd1;
  localparam logic [3:0] reg_ports  = 4'd2;
  localparam logic [3:0] reg_window = 4'd3;
  localparam logic [3:0] reg_ctrl   = 4'd4;

endpackage

/* tcp_tx_cfg.sv */
module tcp_tx_cfg
  import tcp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cfg_we,
  input  logic [3:0]  cfg_addr,
  input  logic [31:0] cfg_wdata,
  output ipv4_addr_t  loc_ip,
  output ipv4_addr_t  rem_ip,
  output port_t       loc_port,
  output port_t       rem_port,
  output logic [15:0] window,
  output logic        connected
);

  // One register per address, written a whole word at a time
  always_ff @(posedge clk) begin
    if (rst) begin
      loc_ip    <= '0;
      rem_ip    <= '0;
      loc_port  <= '0;
      rem_port  <= '0;
      window    <= '0;
      connected <= 1'b0;
    end else if (cfg_we) begin
      case (cfg_addr)
        reg_loc_ip: begin
          loc_ip <= cfg_wdata;
        end
        reg_rem_ip: begin
          rem_ip <= cfg_wdata;
        end
        reg_ports: begin
          // Local port sits in the upper half
          loc_port <= cfg_wdata[31:16];
          rem_port <= cfg_wdata[15:0];
        end
        reg_window: begin
          window <= cfg_wdata[15:0];
        end
        reg_ctrl: begin
          connected <= cfg_wdata[0];
        end
        default: begin
          // Writes to unmapped addresses are dropped
        end
      endcase
    end
  end

endmodule

/* tcp_tx_arb.sv */
module tcp_tx_arb
  import tcp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        connected,
  input  ipv4_addr_t  loc_ip,
  input  ipv4_addr_t  rem_ip,
  input  port_t       loc_port,
  input  port_t       rem_port,
  input  logic [15:0] window,
  input  logic        send_pld,
  input  logic        send_ka,
  input  logic        send_ack,
  input  tcp_num_t    loc_seq,
  input  tcp_num_t    loc_ack,
  input  tcp_num_t    pld_seq,
  input  logic [15:0] pld_len,
  input  logic        hdr_acc,
  input  logic        hdr_done,
  output logic        pld_sent,
  output logic        ka_sent,
  output logic        ack_sent,
  output logic        hdr_valid,
  output ipv4_addr_t  src_ip,
  output ipv4_addr_t  dst_ip,
  output logic [15:0] ip_id,
  output logic [15:0] ip_len,
  output port_t       src_port,
  output port_t       dst_port,
  output tcp_num_t    seq_num,
  output tcp_num_t    ack_num,
  output tcp_flags_t  flags,
  output logic [15:0] window_out
);

  typedef enum logic [1:0] {
    idle_s,
    active_s,
    sent_s
  } state_t;

  typedef enum logic [1:0] {
    tx_none,
    tx_pld,
    tx_ka,
    tx_ack
  } tx_type_t;

  state_t      state;
  tx_type_t    tx_type;
  logic [15:0] ip_id_cnt;
  logic        start;
  logic        any_sent;

  // Requests are only served on an established connection
  assign start    = (state == idle_s) && connected && (send_pld || send_ka || send_ack);
  assign any_sent = pld_sent || ka_sent || ack_sent;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle_s;
      tx_type   <= tx_none;
      hdr_valid <= 1'b0;
      pld_sent  <= 1'b0;
      ka_sent   <= 1'b0;
      ack_sent  <= 1'b0;
      ip_id_cnt <= '0;
    end else begin
      if (hdr_acc) begin
        ip_id_cnt <= ip_id_cnt + 16'd1;
      end
      case (state)
        idle_s: begin
          if (start) begin
            hdr_valid <= 1'b1;
            state     <= active_s;
            if (send_pld) begin
              tx_type <= tx_pld;
            end else if (send_ka) begin
              tx_type <= tx_ka;
            end else begin
              tx_type <= tx_ack;
            end
          end
        end
        active_s: begin
          if (hdr_acc) begin
            hdr_valid <= 1'b0;
          end
          if (any_sent) begin
            // The reply has been up for one cycle
            pld_sent <= 1'b0;
            ka_sent  <= 1'b0;
            ack_sent <= 1'b0;
            tx_type  <= tx_none;
            state    <= sent_s;
          end else if (hdr_done) begin
            pld_sent <= (tx_type == tx_pld);
            ka_sent  <= (tx_type == tx_ka);
            ack_sent <= (tx_type == tx_ack);
          end
        end
        sent_s: begin
          // Gives the requester a cycle to drop its level
          state <= idle_s;
        end
        default: begin
          state <= idle_s;
        end
      endcase
    end
  end

  // Header fields, held stable from start until the next segment
  always_ff @(posedge clk) begin
    if (start) begin
      src_ip     <= loc_ip;
      dst_ip     <= rem_ip;
      src_port   <= loc_port;
      dst_port   <= rem_port;
      ack_num    <= loc_ack;
      window_out <= window;
      ip_id      <= ip_id_cnt;
      if (send_pld) begin
        flags   <= tcp_flag_psh | tcp_flag_ack;
        seq_num <= pld_seq;
        ip_len  <= hdr_len + pld_len;
      end else if (send_ka) begin
        // Keep-alive probes one byte below the next sequence number
        flags   <= tcp_flag_ack;
        seq_num <= loc_seq - 32'd1;
        ip_len  <= hdr_len;
      end else begin
        flags   <= tcp_flag_ack;
        seq_num <= loc_seq;
        ip_len  <= hdr_len;
      end
    end
  end

endmodule

/* tcp_tx_hdr_ser.sv */
module tcp_tx_hdr_ser
  import tcp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        hdr_valid,
  input  ipv4_addr_t  src_ip,
  input  ipv4_addr_t  dst_ip,
  input  logic [15:0] ip_id,
  input  logic [15:0] ip_len,
  input  port_t       src_port,
  input  port_t       dst_port,
  input  tcp_num_t    seq_num,
  input  tcp_num_t    ack_num,
  input  tcp_flags_t  flags,
  input  logic [15:0] window,
  input  logic        credit,
  output logic        hdr_acc,
  output logic        hdr_done,
  output logic        out_valid,
  output logic [31:0] out_data,
  output logic        out_last
);

  typedef enum logic [1:0] {
    idle_s,
    cks_s,
    send_s
  } state_t;

  localparam logic [3:0] last_idx = 4'(hdr_words - 1);

  state_t              state;
  logic [3:0]          word_idx;
  logic [credit_w-1:0] credit_cnt;
  logic [19:0]         cks_sum;
  logic [16:0]         cks_fold1;
  logic [15:0]         cks_fold2;
  logic [15:0]         ip_cks;

  ipv4_addr_t  lat_src_ip;
  ipv4_addr_t  lat_dst_ip;
  logic [15:0] lat_ip_id;
  logic [15:0] lat_ip_len;
  port_t       lat_src_port;
  port_t       lat_dst_port;
  tcp_num_t    lat_seq_num;
  tcp_num_t    lat_ack_num;
  tcp_flags_t  lat_flags;
  logic [15:0] lat_window;

  assign hdr_acc   = (state == idle_s) && hdr_valid;
  assign out_valid = (state == send_s) && (credit_cnt != '0);
  assign out_last  = out_valid && (word_idx == last_idx);
  assign hdr_done  = out_last;

  always_ff @(posedge clk) begin
    if (hdr_acc) begin
      lat_src_ip   <= src_ip;
      lat_dst_ip   <= dst_ip;
      lat_ip_id    <= ip_id;
      lat_ip_len   <= ip_len;
      lat_src_port <= src_port;
      lat_dst_port <= dst_port;
      lat_seq_num  <= seq_num;
      lat_ack_num  <= ack_num;
      lat_flags    <= flags;
      lat_window   <= window;
    end
    if (state == cks_s) begin
      ip_cks <= ~cks_fold2;
    end
  end

  // Nine IPv4 halfwords, the checksum halfword counts as zero
  always_comb begin
    cks_sum = 20'({ipv4_ver_ihl, 8'h00}) + 20'(lat_ip_len) + 20'(lat_ip_id) +
              20'(ipv4_flags_df) + 20'({ipv4_ttl, ipv4_proto_tcp}) +
              20'(lat_src_ip[31:16]) + 20'(lat_src_ip[15:0]) +
              20'(lat_dst_ip[31:16]) + 20'(lat_dst_ip[15:0]);
    cks_fold1 = {1'b0, cks_sum[15:0]} + {13'h0, cks_sum[19:16]};
    cks_fold2 = cks_fold1[15:0] + {15'h0, cks_fold1[16]};
  end

  always_comb begin
    case (word_idx)
      4'd0:    out_data = {ipv4_ver_ihl, 8'h00, lat_ip_len};
      4'd1:    out_data = {lat_ip_id, ipv4_flags_df};
      4'd2:    out_data = {ipv4_ttl, ipv4_proto_tcp, ip_cks};
      4'd3:    out_data = lat_src_ip;
      4'd4:    out_data = lat_dst_ip;
      4'd5:    out_data = {lat_src_port, lat_dst_port};
      4'd6:    out_data = lat_seq_num;
      4'd7:    out_data = lat_ack_num;
      4'd8:    out_data = {tcp_data_offset, 4'h0, lat_flags, lat_window};
      default: out_data = 32'h0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle_s;
      word_idx <= '0;
    end else begin
      case (state)
        idle_s: begin
          if (hdr_acc) begin
            state <= cks_s;
          end
        end
        cks_s: begin
          word_idx <= '0;
          state    <= send_s;
        end
        send_s: begin
          if (out_last) begin
            state <= idle_s;
          end else if (out_valid) begin
            word_idx <= word_idx + 4'd1;
          end
        end
        default: begin
          state <= idle_s;
        end
      endcase
    end
  end

  // Each emitted word spends a credit, each credit pulse returns one
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= credit_w'(credit_depth);
    end else if (credit && !out_valid) begin
      if (credit_cnt != credit_w'(credit_depth)) begin
        credit_cnt <= credit_cnt + 1'b1;
      end
    end else if (!credit && out_valid) begin
      credit_cnt <= credit_cnt - 1'b1;
    end
  end

endmodule

/* tcp_tx_top.sv */
module tcp_tx_top
  import tcp_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cfg_we,
  input  logic [3:0]  cfg_addr,
  input  logic [31:0] cfg_wdata,
  input  logic        send_pld,
  input  logic        send_ka,
  input  logic        send_ack,
  output logic        pld_sent,
  output logic        ka_sent,
  output logic        ack_sent,
  input  tcp_num_t    loc_seq,
  input  tcp_num_t    loc_ack,
  input  tcp_num_t    pld_seq,
  input  logic [15:0] pld_len,
  input  logic        credit,
  output logic        out_valid,
  output logic [31:0] out_data,
  output logic        out_last
);

  ipv4_addr_t  loc_ip;
  ipv4_addr_t  rem_ip;
  port_t       loc_port;
  port_t       rem_port;
  logic [15:0] window;
  logic        connected;

  logic        hdr_valid;
  logic        hdr_acc;
  logic        hdr_done;
  ipv4_addr_t  src_ip;
  ipv4_addr_t  dst_ip;
  logic [15:0] ip_id;
  logic [15:0] ip_len;
  port_t       src_port;
  port_t       dst_port;
  tcp_num_t    seq_num;
  tcp_num_t    ack_num;
  tcp_flags_t  flags;
  logic [15:0] hdr_window;

  tcp_tx_cfg u_cfg (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .loc_ip    (loc_ip),
    .rem_ip    (rem_ip),
    .loc_port  (loc_port),
    .rem_port  (rem_port),
    .window    (window),
    .connected (connected)
  );

  tcp_tx_arb u_arb (
    .clk        (clk),
    .rst        (rst),
    .connected  (connected),
    .loc_ip     (loc_ip),
    .rem_ip     (rem_ip),
    .loc_port   (loc_port),
    .rem_port   (rem_port),
    .window     (window),
    .send_pld   (send_pld),
    .send_ka    (send_ka),
    .send_ack   (send_ack),
    .loc_seq    (loc_seq),
    .loc_ack    (loc_ack),
    .pld_seq    (pld_seq),
    .pld_len    (pld_len),
    .hdr_acc    (hdr_acc),
    .hdr_done   (hdr_done),
    .pld_sent   (pld_sent),
    .ka_sent    (ka_sent),
    .ack_sent   (ack_sent),
    .hdr_valid  (hdr_valid),
    .src_ip     (src_ip),
    .dst_ip     (dst_ip),
    .ip_id      (ip_id),
    .ip_len     (ip_len),
    .src_port   (src_port),
    .dst_port   (dst_port),
    .seq_num    (seq_num),
    .ack_num    (ack_num),
    .flags      (flags),
    .window_out (hdr_window)
  );

  tcp_tx_hdr_ser u_ser (
    .clk       (clk),
    .rst       (rst),
    .hdr_valid (hdr_valid),
    .src_ip    (src_ip),
    .dst_ip    (dst_ip),
    .ip_id     (ip_id),
    .ip_len    (ip_len),
    .src_port  (src_port),
    .dst_port  (dst_port),
    .seq_num   (seq_num),
    .ack_num   (ack_num),
    .flags     (flags),
    .window    (hdr_window),
    .credit    (credit),
    .hdr_acc   (hdr_acc),
    .hdr_done  (hdr_done),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_last  (out_last)
  );

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
  output logic clk
);

  // Period of 4 time units
  initial begin
    clk = 1'b0;
  end

  always begin
    #2 clk = ~clk;
  end

endmodule

/* tcp_tx_tb.sv */
module tcp_tx_tb
  import tcp_tx_pkg::*;
();

  localparam ipv4_addr_t  cfg_loc_ip   = 32'h0a00_0001;
  localparam ipv4_addr_t  cfg_rem_ip   = 32'hc0a8_0105;
  localparam port_t       cfg_loc_port = 16'h1f90;
  localparam port_t       cfg_rem_port = 16'hc350;
  localparam logic [15:0] cfg_window   = 16'h7210;
  localparam int          n_rows       = 8;

  // The req field is {payload, keep-alive, ack} in the order of the sent pulses
  typedef struct packed {
    logic [2:0]  req;
    logic        disc;
    tcp_num_t    loc_seq;
    tcp_num_t    loc_ack;
    tcp_num_t    pld_seq;
    logic [15:0] pld_len;
    logic [3:0]  gap;
  } row_t;

  logic        clk;
  logic        rst;
  logic        cfg_we;
  logic [3:0]  cfg_addr;
  logic [31:0] cfg_wdata;
  logic        send_pld;
  logic        send_ka;
  logic        send_ack;
  logic        pld_sent;
  logic        ka_sent;
  logic        ack_sent;
  tcp_num_t    loc_seq;
  tcp_num_t    loc_ack;
  tcp_num_t    pld_seq;
  logic [15:0] pld_len;
  logic        credit;
  logic        out_valid;
  logic [31:0] out_data;
  logic        out_last;

  row_t        rows [n_rows];
  logic [31:0] exp_q [$];
  logic [2:0]  kind_q [$];
  int unsigned ret_q [$];
  logic [15:0] exp_id;
  logic [31:0] exp_word;
  logic [2:0]  sent_exp;
  logic        last_exp;
  int          word_cnt;
  int          tb_credits;
  int unsigned cur_gap;
  int unsigned cyc;

  tb_clk_gen u_clk (
    .clk (clk)
  );

  tcp_tx_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .send_pld  (send_pld),
    .send_ka   (send_ka),
    .send_ack  (send_ack),
    .pld_sent  (pld_sent),
    .ka_sent   (ka_sent),
    .ack_sent  (ack_sent),
    .loc_seq   (loc_seq),
    .loc_ack   (loc_ack),
    .pld_seq   (pld_seq),
    .pld_len   (pld_len),
    .credit    (credit),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_last  (out_last)
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  // Builds the ten header words of one segment straight from the header format
  function automatic void push_segment(input logic [2:0] kind, input tcp_num_t seq,
                                       input tcp_num_t ack, input logic [15:0] len);
    logic [31:0] w [10];
    logic [31:0] sum;
    logic [7:0]  fl;
    int          i;
    fl   = (kind == 3'b100) ? 8'h18 : 8'h10;
    w[0] = {8'h45, 8'h00, len};
    w[1] = {exp_id, 16'h4000};
    w[2] = {8'd64, 8'd6, 16'h0000};
    w[3] = cfg_loc_ip;
    w[4] = cfg_rem_ip;
    w[5] = {cfg_loc_port, cfg_rem_port};
    w[6] = seq;
    w[7] = ack;
    w[8] = {4'd5, 4'h0, fl, cfg_window};
    w[9] = 32'h0;
    sum  = 32'h0;
    for (i = 0; i < 5; i++) begin
      sum = sum + {16'h0, w[i][31:16]} + {16'h0, w[i][15:0]};
    end
    while (sum[31:16] != 16'h0) begin
      sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
    end
    w[2][15:0] = ~sum[15:0];
    for (i = 0; i < 10; i++) begin
      exp_q.push_back(w[i]);
    end
    kind_q.push_back(kind);
    exp_id = exp_id + 16'd1;
  endfunction

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_we <= 1'b0;
  endtask

  task automatic run_row(input row_t row);
    logic [2:0] pending;
    cur_gap = {28'h0, row.gap};
    if (row.disc) begin
      write_reg(reg_ctrl, 32'h0);
    end
    @(posedge clk);
    loc_seq  <= row.loc_seq;
    loc_ack  <= row.loc_ack;
    pld_seq  <= row.pld_seq;
    pld_len  <= row.pld_len;
    send_pld <= row.req[2];
    send_ka  <= row.req[1];
    send_ack <= row.req[0];
    // Service order is fixed by priority, not by the order of the requests
    if (row.req[2]) begin
      push_segment(3'b100, row.pld_seq, row.loc_ack, 16'd40 + row.pld_len);
    end
    if (row.req[1]) begin
      push_segment(3'b010, row.loc_seq - 32'd1, row.loc_ack, 16'd40);
    end
    if (row.req[0]) begin
      push_segment(3'b001, row.loc_seq, row.loc_ack, 16'd40);
    end
    if (row.disc) begin
      repeat (50) begin
        @(posedge clk);
        assert (!out_valid && !pld_sent && !ka_sent && !ack_sent)
          else stop_on_error("Requests were served while the connection was down");
      end
      write_reg(reg_ctrl, 32'h1);
    end
    pending = row.req;
    while (pending != 3'b000) begin
      @(posedge clk);
      if (pld_sent) begin
        send_pld   <= 1'b0;
        pending[2] = 1'b0;
      end
      if (ka_sent) begin
        send_ka    <= 1'b0;
        pending[1] = 1'b0;
      end
      if (ack_sent) begin
        send_ack   <= 1'b0;
        pending[0] = 1'b0;
      end
    end
  endtask

  task automatic load_table();
    rows[0] = '{3'b100, 1'b0, 32'h0000_1000, 32'h8000_0001, 32'h0000_1000, 16'd512, 4'd0};
    rows[1] = '{3'b010, 1'b0, 32'h0000_1200, 32'h8000_0001, 32'h0000_0000, 16'd0, 4'd1};
    rows[2] = '{3'b001, 1'b0, 32'h0000_1200, 32'h8000_0400, 32'h0000_0000, 16'd0, 4'd2};
    rows[3] = '{3'b111, 1'b0, 32'h0000_1200, 32'h8000_0800, 32'h0000_1200, 16'd1460, 4'd3};
    rows[4] = '{3'b101, 1'b0, 32'h0001_0000, 32'h8000_0c00, 32'h0000_17b4, 16'd100, 4'd7};
    rows[5] = '{3'b011, 1'b0, 32'h0001_0000, 32'hffff_fff0, 32'h0000_0000, 16'd0, 4'd15};
    rows[6] = '{3'b110, 1'b1, 32'h7fff_0000, 32'h0000_0010, 32'h7ffe_fff0, 16'd65495, 4'd1};
    // Keep-alive at sequence zero wraps to all ones
    rows[7] = '{3'b111, 1'b0, 32'h0000_0000, 32'h1234_5678, 32'hffff_fffc, 16'd8, 4'd4};
  endtask

  initial begin
    rst       = 1'b1;
    cfg_we    = 1'b0;
    cfg_addr  = 4'h0;
    cfg_wdata = 32'h0;
    send_pld  = 1'b0;
    send_ka   = 1'b0;
    send_ack  = 1'b0;
    loc_seq   = 32'h0;
    loc_ack   = 32'h0;
    pld_seq   = 32'h0;
    pld_len   = 16'h0;
    exp_id    = 16'h0;
    cur_gap   = 0;
    load_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    write_reg(reg_loc_ip, cfg_loc_ip);
    write_reg(reg_rem_ip, cfg_rem_ip);
    write_reg(reg_ports, {cfg_loc_port, cfg_rem_port});
    write_reg(reg_window, {16'habcd, cfg_window});
    // An unmapped address must leave every register alone
    write_reg(4'd9, 32'hffff_ffff);
    write_reg(reg_ctrl, 32'h1);
    for (int r = 0; r < n_rows; r++) begin
      run_row(rows[r]);
    end
    repeat (4) @(posedge clk);
    $display("all tests passed");
    $finish;
  end

  // Downstream model that returns each consumed word's credit after a random gap
  initial begin
    void'($urandom(20025));
    credit     = 1'b0;
    tb_credits = credit_depth;
    cyc        = 0;
    forever begin
      @(posedge clk);
      cyc = cyc + 1;
      if (!rst) begin
        if (out_valid) begin
          assert (tb_credits > 0)
            else stop_on_error("out_valid was high while no credit was left");
          ret_q.push_back(cyc + ($urandom % (cur_gap + 1)));
        end
        tb_credits = tb_credits + (credit ? 1 : 0) - (out_valid ? 1 : 0);
        if (ret_q.size() > 0 && ret_q[0] <= cyc) begin
          void'(ret_q.pop_front());
          credit <= 1'b1;
        end else begin
          credit <= 1'b0;
        end
      end
    end
  end

  initial begin
    word_cnt = 0;
    sent_exp = 3'b000;
    forever begin
      @(posedge clk);
      if (!rst) begin
        // A sent pulse is due exactly one cycle after the segment's last word
        assert ({pld_sent, ka_sent, ack_sent} == sent_exp)
          else stop_on_error($sformatf("ERROR: {pld_sent,ka_sent,ack_sent} got 0x%0h expected 0x%0h",
                                       {pld_sent, ka_sent, ack_sent}, sent_exp));
        sent_exp = 3'b000;
        if (out_valid) begin
          assert (exp_q.size() > 0)
            else stop_on_error("out_valid went high with no segment outstanding");
          if (exp_q.size() > 0) begin
            exp_word = exp_q.pop_front();
            last_exp = (word_cnt == hdr_words - 1);
            assert (out_data == exp_word)
              else stop_on_error($sformatf("ERROR: out_data word %0d got 0x%08h expected 0x%08h",
                                           word_cnt, out_data, exp_word));
            assert (out_last == last_exp)
              else stop_on_error($sformatf("ERROR: out_last got 0x%0h expected 0x%0h",
                                           out_last, last_exp));
            if (last_exp) begin
              word_cnt = 0;
              sent_exp = kind_q.pop_front();
            end else begin
              word_cnt = word_cnt + 1;
            end
          end
        end else begin
          assert (!out_last)
            else stop_on_error("ERROR: out_last got 0x1 expected 0x0 with out_valid low");
        end
      end
    end
  end

  initial begin
    repeat ((n_rows + 1) * 200) @(posedge clk);
    stop_on_error("Timeout: the run did not finish within the watchdog limit");
  end

endmodule

/* tcp_tx.f */
tcp_tx_pkg.sv
tcp_tx_cfg.sv
tcp_tx_arb.sv
tcp_tx_hdr_ser.sv
tcp_tx_top.sv
tb_clk_gen.sv
tcp_tx_tb.sv

/* Makefile */
SRCS = $(shell cat tcp_tx.f)
SIM  = obj_dir/Vtcp_tx_tb

.PHONY: all run clean

all: run

$(SIM): $(SRCS) tcp_tx.f
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tcp_tx_tb -f tcp_tx.f

run: $(SIM)
	./$(SIM) | tee sim.log
	! grep -q "tests failed" sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
